// ==== cache_controller.sv ====
// miss FSM of the data cache with stall, memory request and address select
`timescale 1ns/1ps

module cache_controller
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       proc_read,
	input  logic       proc_write,
	input  proc_addr_t proc_addr,
	input  logic       hit,
	input  logic       victim_dirty,
	input  tag_t       victim_tag,
	input  logic       mem_ready,
	output logic       proc_stall,
	output logic       access_en,
	output logic       access_write,
	output logic       fill_en,
	output logic       mem_read,
	output logic       mem_write,
	output line_addr_t mem_addr
);

	cache_state_t state, state_n;

	logic   req;
	index_t req_index;

	assign req       = proc_read || proc_write;
	assign req_index = proc_addr[OFFSET_W +: INDEX_W];

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_n;
		end
	end

	always_comb begin
		state_n = state;
		case (state)
			st_idle: begin
				if (req && !hit) begin
					// dirty victim must reach memory before the fill
					state_n = victim_dirty ? st_write_back : st_allocate;
				end
			end
			st_write_back: begin
				if (mem_ready) begin
					state_n = st_allocate;
				end
			end
			st_allocate: begin
				if (mem_ready) begin
					state_n = st_idle;  // request hits next cycle
				end
			end
			default: begin
				state_n = st_idle;
			end
		endcase
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	// only an idle hit finishes without stalling
	assign proc_stall   = req && !(state == st_idle && hit);
	assign access_en    = req && (state == st_idle) && hit;
	assign access_write = access_en && proc_write;
	assign fill_en      = (state == st_allocate) && mem_ready;

	assign mem_write = (state == st_write_back);
	assign mem_read  = (state == st_allocate);

	// victim line on write-back, requested line otherwise
	always_comb begin
		if (state == st_write_back) begin
			mem_addr = {victim_tag, req_index};
		end else begin
			mem_addr = proc_addr[ADDR_W-1:OFFSET_W];
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_rd_wr_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write)
	) else $error("mem_read and mem_write both high");

	// address holds until the memory answers
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(mem_read || mem_write) && !mem_ready |=> $stable(mem_addr)
	) else $error("mem_addr changed while waiting for mem_ready");

	a_no_idle_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		!req |-> !proc_stall
	) else $error("proc_stall high with no request");

	// a transfer that ends in allocate is followed by a completed access
	a_fill_completes: assert property (
		@(posedge clk) disable iff (!rst_n)
		fill_en |=> !proc_stall
	) else $error("request still stalled after the fill");

endmodule

// ==== cache_data_store.sv ====
// data array of the two-way cache with word access and whole-line fill and readout
`timescale 1ns/1ps

module cache_data_store
	import cache_pkg::*;
(
	input  logic    clk,
	input  index_t  index,
	input  offset_t offset,
	input  logic    hit_way,
	input  logic    victim_way,
	input  logic    word_we,
	input  word_t   wdata,
	output word_t   rdata,
	input  logic    fill_en,
	input  line_t   fill_line,
	output line_t   victim_line
);

	line_t lines [SETS][WAYS];

	line_t hit_line;

	// ------------------------------------------------------------
	// combinational reads
	// ------------------------------------------------------------
	assign hit_line    = lines[index][hit_way];
	assign rdata       = hit_line[offset*WORD_W +: WORD_W];
	assign victim_line = lines[index][victim_way];  // write-back data

	// ------------------------------------------------------------
	// writes
	// ------------------------------------------------------------
	// fill goes to the victim way, a store to the hit way
	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[index][victim_way] <= fill_line;
		end else if (word_we) begin
			lines[index][hit_way][offset*WORD_W +: WORD_W] <= wdata;
		end
	end

endmodule

// ==== cache_pkg.sv ====
// data cache package with widths, address field types and controller states
package cache_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------
	localparam int WORD_W      = 32;
	localparam int ADDR_W      = 30;                           // processor word address
	localparam int OFFSET_W    = 2;                            // word in line
	localparam int INDEX_W     = 2;                            // set select
	localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;  // 26
	localparam int LINE_WORDS  = 4;
	localparam int SETS        = 4;
	localparam int WAYS        = 2;
	localparam int LINE_W      = LINE_WORDS * WORD_W;          // 128
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;            // 28, memory line address

	// ------------------------------------------------------------
	// payload and address types
	// ------------------------------------------------------------
	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits in the low bits
	typedef logic [LINE_W-1:0] line_t;

	// {tag, index, offset} from the top down
	typedef logic [ADDR_W-1:0] proc_addr_t;

	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// {tag, index}
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// miss handling FSM
	typedef enum logic [1:0] {
		st_idle       = 2'd0,
		st_write_back = 2'd1,
		st_allocate   = 2'd2
	} cache_state_t;

endpackage

// ==== cache_tag_store.sv ====
// tag store for the two-way data cache with hit detection, LRU and victim choice
`timescale 1ns/1ps

module cache_tag_store
	import cache_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  index_t index,
	input  tag_t   tag,
	input  logic   access_en,     // completed hit access
	input  logic   access_write,
	input  logic   fill_en,       // line arrived from memory
	output logic   hit,
	output logic   hit_way,
	output logic   victim_way,
	output tag_t   victim_tag,
	output logic   victim_dirty
);

	// ------------------------------------------------------------
	// state per set
	// ------------------------------------------------------------
	tag_t                       tags [SETS][WAYS];  // payload, no reset
	logic [SETS-1:0][WAYS-1:0]  valid;
	logic [SETS-1:0][WAYS-1:0]  dirty;
	logic [SETS-1:0]            lru;                // way to evict next

	logic [WAYS-1:0] way_match;

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_match[w] = valid[index][w] && (tags[index][w] == tag);
		end
	end

	assign hit     = |way_match;
	assign hit_way = way_match[1];  // way 0 when nothing matches

	// an empty way is taken before the LRU one
	always_comb begin
		if (!valid[index][0]) begin
			victim_way = 1'b0;
		end else if (!valid[index][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru[index];
		end
	end

	assign victim_tag   = tags[index][victim_way];
	assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];

	// ------------------------------------------------------------
	// update
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else if (fill_en) begin
			valid[index][victim_way] <= 1'b1;
			dirty[index][victim_way] <= 1'b0;  // fresh from memory
			lru[index]               <= ~victim_way;
		end else if (access_en) begin
			lru[index] <= ~hit_way;
			if (access_write) begin
				dirty[index][hit_way] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[index][victim_way] <= tag;
		end
	end

	// a fill makes the same tag hit on the next cycle
	a_fill_then_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		fill_en ##1 ($stable(index) && $stable(tag)) |-> hit
	) else $error("filled line does not hit");

endmodule

// ==== dcache.sv ====
// two-way set-associative write-back data cache, top level
`timescale 1ns/1ps

module dcache
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// processor side
	input  logic       proc_read,
	input  logic       proc_write,
	input  proc_addr_t proc_addr,
	input  word_t      proc_wdata,
	output logic       proc_stall,
	output word_t      proc_rdata,
	// memory side
	output logic       mem_read,
	output logic       mem_write,
	output line_addr_t mem_addr,
	output line_t      mem_wdata,
	input  line_t      mem_rdata,
	input  logic       mem_ready
);

	// ------------------------------------------------------------
	// address fields and internal wires
	// ------------------------------------------------------------
	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;

	logic access_en;
	logic access_write;
	logic fill_en;
	logic hit;
	logic hit_way;
	logic victim_way;
	tag_t victim_tag;
	logic victim_dirty;

	assign req_tag    = proc_addr[ADDR_W-1 -: TAG_W];
	assign req_index  = proc_addr[OFFSET_W +: INDEX_W];
	assign req_offset = proc_addr[OFFSET_W-1:0];

	// ------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------
	cache_tag_store u_tag_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.index        (req_index),
		.tag          (req_tag),
		.access_en    (access_en),
		.access_write (access_write),
		.fill_en      (fill_en),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_tag   (victim_tag),
		.victim_dirty (victim_dirty)
	);

	cache_data_store u_data_store (
		.clk         (clk),
		.index       (req_index),
		.offset      (req_offset),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.word_we     (access_write),  // store on a completed write hit
		.wdata       (proc_wdata),
		.rdata       (proc_rdata),
		.fill_en     (fill_en),
		.fill_line   (mem_rdata),
		.victim_line (mem_wdata)
	);

	cache_controller u_controller (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.access_en    (access_en),
		.access_write (access_write),
		.fill_en      (fill_en),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -f sources.f \
	--Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sources.f ====
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_controller.sv
dcache.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_dcache.sv

// ==== tb_clock_gen.sv ====
// testbench clock and reset source, 20 ns clock with active-low reset for two cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (2) @(negedge clk);  // covers two rising edges
		rst_n = 1'b1;
	end

endmodule

// ==== tb_dcache.sv ====
// testbench for the two-way data cache with shadow model, checking assertions and watchdog
`timescale 1ns/1ps

module tb_dcache
	import cache_pkg::*;
();

	localparam int          N_DIRECTED = 8;
	localparam int          N_RANDOM   = 400;
	localparam int          N_OPS      = N_DIRECTED + N_RANDOM;
	localparam logic [31:0] SEED       = 32'h35c396ed;

	logic       clk;
	logic       rst_n;
	logic       proc_read;
	logic       proc_write;
	proc_addr_t proc_addr;
	word_t      proc_wdata;
	logic       proc_stall;
	word_t      proc_rdata;
	logic       mem_read;
	logic       mem_write;
	line_addr_t mem_addr;
	line_t      mem_wdata;
	line_t      mem_rdata;
	logic       mem_ready;
	logic       req;

	// expectations for the request on the bus
	logic       exp_miss;
	logic       exp_wb;
	line_addr_t exp_line_addr;
	line_addr_t exp_wb_addr;
	line_t      exp_wb_data;
	word_t      exp_rdata;

	logic completed;  // request finished on the last edge
	logic fill_seen;
	logic wb_seen;

	word_t       shadow [128];  // indexed by {tag, index, offset}
	logic [2:0]  model_tag [SETS][WAYS];
	logic        model_valid [SETS][WAYS];
	logic        model_dirty [SETS][WAYS];
	logic        model_lru [SETS];
	logic [31:0] lfsr_state;
	int          value_errors;
	int          other_errors;

	tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));
	dcache UUT (.*);
	tb_mem_model u_mem (.*);

	assign req = proc_read || proc_write;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t initial_word(input logic [31:0] a);
		initial_word = {~a[31:16], a[15:0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_value(input string name, input string expected, input string actual);
		value_errors++;
		$display("FAILED %s: expected %s, actual %s", name, expected, actual);
	endtask

	task automatic report_other(input string what);
		other_errors++;
		$display("ERROR: %s", what);
	endtask

	// ------------------------------------------------------------
	// one request, called on a falling edge
	// ------------------------------------------------------------
	task automatic do_access(input logic wr, input logic [2:0] t, input index_t idx,
			input offset_t off, input word_t wd);
		logic       hit_m;
		logic       way;
		logic [2:0] vt;
		hit_m = 1'b1;
		way   = 1'b0;
		if (model_valid[idx][0] && model_tag[idx][0] == t) begin
			way = 1'b0;
		end else if (model_valid[idx][1] && model_tag[idx][1] == t) begin
			way = 1'b1;
		end else begin
			hit_m = 1'b0;
			if (!model_valid[idx][0]) way = 1'b0;         // empty way first
			else if (!model_valid[idx][1]) way = 1'b1;
			else way = model_lru[idx];
		end
		vt            = model_tag[idx][way];
		exp_miss      = !hit_m;
		exp_wb        = !hit_m && model_valid[idx][way] && model_dirty[idx][way];
		exp_wb_addr   = {23'd0, vt, idx};
		exp_wb_data   = {shadow[{vt, idx, 2'd3}], shadow[{vt, idx, 2'd2}],
			shadow[{vt, idx, 2'd1}], shadow[{vt, idx, 2'd0}]};
		exp_line_addr = {23'd0, t, idx};
		exp_rdata     = shadow[{t, idx, off}];
		proc_read     = !wr;
		proc_write    = wr;
		proc_addr     = {23'd0, t, idx, off};
		proc_wdata    = wd;
		do @(negedge clk); while (!completed);
		if (wr) shadow[{t, idx, off}] = wd;
		if (!hit_m) begin
			model_tag[idx][way]   = t;
			model_valid[idx][way] = 1'b1;
			model_dirty[idx][way] = 1'b0;
		end
		model_lru[idx] = !way;
		if (wr) model_dirty[idx][way] = 1'b1;
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			completed <= 1'b0;
			fill_seen <= 1'b0;
			wb_seen   <= 1'b0;
		end else begin
			completed <= req && !proc_stall;
			if (req && !proc_stall) begin
				fill_seen <= 1'b0;
				wb_seen   <= 1'b0;
			end else begin
				if (mem_read && mem_ready) fill_seen <= 1'b1;
				if (mem_write && mem_ready) wb_seen <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!req |-> !proc_stall && !mem_read && !mem_write)
		else report_other("stall or memory request with no processor request");
	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		proc_read && !proc_stall |-> proc_rdata == exp_rdata)
		else report_value("read_data", $sformatf("%h", $sampled(exp_rdata)),
			$sformatf("%h", $sampled(proc_rdata)));
	a_hit_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
		req && !exp_miss |-> !proc_stall)
		else report_other("request to a resident line was stalled");
	a_miss_fill: assert property (@(posedge clk) disable iff (!rst_n)
		req && !proc_stall |-> fill_seen == exp_miss)
		else report_value("miss_fill", $sformatf("%h", $sampled(exp_miss)),
			$sformatf("%h", $sampled(fill_seen)));
	a_fill_addr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_read |-> mem_addr == exp_line_addr)
		else report_value("fill_addr", $sformatf("%h", $sampled(exp_line_addr)),
			$sformatf("%h", $sampled(mem_addr)));
	a_wb_order: assert property (@(posedge clk) disable iff (!rst_n)
		mem_read |-> wb_seen == exp_wb)   // write-back only for a dirty victim
		else report_value("writeback_before_fill", $sformatf("%h", $sampled(exp_wb)),
			$sformatf("%h", $sampled(wb_seen)));
	a_wb_expected: assert property (@(posedge clk) disable iff (!rst_n)
		mem_write |-> exp_wb)
		else report_other("write-back issued without a dirty victim");
	a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_write |-> mem_addr == exp_wb_addr)
		else report_value("writeback_addr", $sformatf("%h", $sampled(exp_wb_addr)),
			$sformatf("%h", $sampled(mem_addr)));
	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_write |-> mem_wdata == exp_wb_data)
		else report_value("writeback_data", $sformatf("%h", $sampled(exp_wb_data)),
			$sformatf("%h", $sampled(mem_wdata)));

	initial begin
		#(N_OPS * 20 * 20);
		report_other("timeout, requests still outstanding");
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		$display("Test failed");
		$finish;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic        wr;
		logic [2:0]  t;
		index_t      idx;
		offset_t     off;
		word_t       wd;
		proc_read    = 1'b0;
		proc_write   = 1'b0;
		proc_addr    = '0;
		proc_wdata   = '0;
		exp_miss     = 1'b0;
		exp_wb       = 1'b0;
		lfsr_state   = SEED;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < 128; i++) shadow[i] = initial_word(32'(i));
		for (int s = 0; s < SETS; s++) begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < WAYS; w++) begin
				model_tag[s][w]   = 3'd0;
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
			end
		end
		@(posedge rst_n);
		repeat (2) @(negedge clk);
		// set 0: cold miss, resident write and read, then a dirty eviction
		do_access(1'b0, 3'd0, 2'd0, 2'd1, '0);
		do_access(1'b1, 3'd0, 2'd0, 2'd2, 32'hdeadbeef);
		do_access(1'b0, 3'd0, 2'd0, 2'd2, '0);
		do_access(1'b1, 3'd1, 2'd0, 2'd0, 32'h12345678);
		do_access(1'b0, 3'd2, 2'd0, 2'd3, '0);
		// set 1: clean eviction
		do_access(1'b0, 3'd0, 2'd1, 2'd0, '0);
		do_access(1'b0, 3'd1, 2'd1, 2'd1, '0);
		do_access(1'b0, 3'd2, 2'd1, 2'd2, '0);
		for (int n = 0; n < N_RANDOM; n++) begin
			take_bits(1, r);
			wr = r[0];
			take_bits(3, r);
			t = r[2:0];
			take_bits(2, r);
			idx = r[1:0];
			take_bits(2, r);
			off = r[1:0];
			wd = '0;
			if (wr) begin
				take_bits(32, r);
				wd = r;
			end
			do_access(wr, t, idx, off, wd);
		end
		proc_read  = 1'b0;
		proc_write = 1'b0;
		repeat (3) @(negedge clk);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb_mem_model.sv ====
// backing line memory for the cache testbench with random ready latency
`timescale 1ns/1ps

module tb_mem_model
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mem_read,
	input  logic       mem_write,
	input  line_addr_t mem_addr,
	input  line_t      mem_wdata,
	output line_t      mem_rdata,
	output logic       mem_ready
);

	localparam int          MEM_LINES = 32;
	localparam logic [31:0] SEED      = 32'h35c396ed;

	line_t       lines [MEM_LINES];
	logic [4:0]  slot;
	logic [31:0] lfsr;
	logic [31:0] lfsr_1;
	logic [31:0] lfsr_2;
	logic [1:0]  wait_cnt;
	logic        busy;  // transfer accepted, ready not yet given

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// word address with the upper half inverted
	function automatic word_t initial_word(input logic [31:0] a);
		initial_word = {~a[31:16], a[15:0]};
	endfunction

	initial begin
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int o = 0; o < LINE_WORDS; o++) begin
				lines[l][o*WORD_W +: WORD_W] = initial_word(32'(l * LINE_WORDS + o));
			end
		end
	end

	assign slot      = mem_addr[4:0];
	assign mem_rdata = lines[slot];
	assign lfsr_1    = lfsr_next(lfsr);    // one step per latency bit
	assign lfsr_2    = lfsr_next(lfsr_1);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			busy      <= 1'b0;
			wait_cnt  <= 2'd0;
			lfsr      <= SEED;
		end else begin
			mem_ready <= 1'b0;  // one-cycle pulse
			if (mem_ready) begin
				busy <= 1'b0;
			end else if (busy) begin
				if (wait_cnt == 2'd0) begin
					mem_ready <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end else if (mem_read || mem_write) begin
				busy     <= 1'b1;
				wait_cnt <= {lfsr_2[0], lfsr_1[0]};
				lfsr     <= lfsr_2;
			end
		end
	end

	always @(posedge clk) begin
		if (mem_ready && mem_write) begin
			lines[slot] <= mem_wdata;
		end
	end

endmodule
